// File: verilog/rvCorePkg.sv
// Shared types for the RV32I multi-cycle core
// Word, register index, funct3 and byte mask widths
// Opcode field values for the ten base instruction classes
// State enum, decoded instruction and store request structs
package rvCorePkg;

   typedef logic [31:0] dataWord;
   typedef logic [4:0]  regIndex;
   typedef logic [2:0]  funct3Field;
   typedef logic [3:0]  byteMask;
   typedef logic [4:0]  opcodeField;

   // Instruction bits 6:2, bits 1:0 are always 11 in RV32I
   localparam opcodeField opLoad   = 5'b00000;
   localparam opcodeField opAluImm = 5'b00100;
   localparam opcodeField opAuipc  = 5'b00101;
   localparam opcodeField opStore  = 5'b01000;
   localparam opcodeField opAluReg = 5'b01100;
   localparam opcodeField opLui    = 5'b01101;
   localparam opcodeField opBranch = 5'b11000;
   localparam opcodeField opJalr   = 5'b11001;
   localparam opcodeField opJal    = 5'b11011;
   localparam opcodeField opSystem = 5'b11100;

   typedef enum logic [1:0] {
      fetchInstr,
      waitInstr,
      execute,
      waitMem
   } coreState;

   // One flag per class, at most one set
   typedef struct packed {
      logic       isLoad;
      logic       isStore;
      logic       isAluImm;
      logic       isAluReg;
      logic       isLui;
      logic       isAuipc;
      logic       isBranch;
      logic       isJal;
      logic       isJalr;
      logic       isSystem;
      regIndex    rd;
      funct3Field funct3;
      logic       isSubOrSra;
      logic       isRegForm;
      dataWord    iImm;
      dataWord    sImm;
      dataWord    bImm;
      dataWord    uImm;
      dataWord    jImm;
   } decodedInstr;

   typedef struct packed {
      dataWord data;
      byteMask mask;
   } storeReq;

endpackage

// File: verilog/instrDecoder.sv
// Instruction decoder
// Opcode class flags, rd and funct3 fields
// Sign-extended I, S, B, U and J immediates
module instrDecoder import rvCorePkg::*; (
   input  dataWord     instrWord,
   output decodedInstr dec
);

   opcodeField opcode;

   assign opcode = instrWord[6:2];

   always_comb begin
      // Class flags, unknown opcodes leave all of them low
      dec.isLoad   = (opcode == opLoad);
      dec.isStore  = (opcode == opStore);
      dec.isAluImm = (opcode == opAluImm);
      dec.isAluReg = (opcode == opAluReg);
      dec.isLui    = (opcode == opLui);
      dec.isAuipc  = (opcode == opAuipc);
      dec.isBranch = (opcode == opBranch);
      dec.isJal    = (opcode == opJal);
      dec.isJalr   = (opcode == opJalr);
      dec.isSystem = (opcode == opSystem);

      dec.rd     = instrWord[11:7];
      dec.funct3 = instrWord[14:12];

      // Bit 30 picks SUB over ADD and SRA over SRL
      dec.isSubOrSra = instrWord[30];
      // Bit 5 separates register ops from immediate ops
      dec.isRegForm  = instrWord[5];

      // I type, loads, JALR and ALU immediates
      dec.iImm = {{21{instrWord[31]}}, instrWord[30:20]};

      // S type, offset split around rd position
      dec.sImm = {{21{instrWord[31]}}, instrWord[30:25], instrWord[11:7]};

      // B type, even offsets only
      dec.bImm = {{20{instrWord[31]}}, instrWord[7], instrWord[30:25],
                  instrWord[11:8], 1'b0};

      // U type, upper 20 bits
      dec.uImm = {instrWord[31:12], 12'h000};

      // J type, even offsets only
      dec.jImm = {{12{instrWord[31]}}, instrWord[19:12], instrWord[20],
                  instrWord[30:21], 1'b0};
   end

endmodule

// File: verilog/registerFile.sv
// Register file, 32 x 32 bits
// Source operands captured from the fetched word
// Single write port, x0 hardwired to zero
module registerFile import rvCorePkg::*; (
   input  logic    clk,
   input  dataWord fetchWord,
   input  logic    fetchCapture,
   input  logic    wbEnable,
   input  regIndex rd,
   input  dataWord wbData,
   output dataWord rs1Value,
   output dataWord rs2Value
);

   dataWord regs [32];
   regIndex rs1Idx;
   regIndex rs2Idx;

   // Source fields straight from the memory bus
   assign rs1Idx = fetchWord[19:15];
   assign rs2Idx = fetchWord[24:20];

   always_ff @(posedge clk) begin
      if (wbEnable && (rd != 5'd0)) begin
         regs[rd] <= wbData;
      end
   end

   // Operands hold until the next fetch
   always_ff @(posedge clk) begin
      if (fetchCapture) begin
         rs1Value <= (rs1Idx == 5'd0) ? '0 : regs[rs1Idx];
         rs2Value <= (rs2Idx == 5'd0) ? '0 : regs[rs2Idx];
      end
   end

endmodule

// File: verilog/aluUnit.sv
// Integer ALU for RV32I
// Adder, 33-bit subtract with compare flags
// Shared right shifter, logic ops and branch predicate
module aluUnit import rvCorePkg::*; (
   input  decodedInstr dec,
   input  dataWord     rs1Value,
   input  dataWord     rs2Value,
   output dataWord     aluResult,
   output dataWord     aluSum,
   output logic        branchTaken
);

   dataWord    aluIn2;
   logic [32:0] aluMinus;
   logic       lt;
   logic       ltu;
   logic       eq;
   dataWord    shiftIn;
   logic [32:0] shiftWide;
   dataWord    shifter;

   function automatic dataWord reverseBits(input dataWord value);
      dataWord result;
      for (int i = 0; i < 32; i++) begin
         result[i] = value[31 - i];
      end
      return result;
   endfunction

   // Register operand for reg ops and branches, else I immediate
   assign aluIn2 = (dec.isAluReg || dec.isBranch) ? rs2Value : dec.iImm;

   // Also the JALR target adder
   assign aluSum = rs1Value + aluIn2;

   // rs1 - aluIn2 with borrow in bit 32
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1Value} + 33'd1;
   assign ltu = aluMinus[32];
   // Signs differ so rs1 sign decides
   assign lt  = (rs1Value[31] ^ aluIn2[31]) ? rs1Value[31] : aluMinus[32];
   assign eq  = (aluMinus[31:0] == 32'd0);

   // SLL runs through the right shifter on reversed bits
   assign shiftIn = (dec.funct3 == 3'b001) ? reverseBits(rs1Value) : rs1Value;
   assign shiftWide = $signed({dec.isSubOrSra & rs1Value[31], shiftIn}) >>> aluIn2[4:0];
   assign shifter = shiftWide[31:0];

   always_comb begin
      case (dec.funct3)
         // SUB only for register form, ADDI has bit 30 in its immediate
         3'b000:  aluResult = (dec.isSubOrSra && dec.isRegForm) ? aluMinus[31:0] : aluSum;
         3'b001:  aluResult = reverseBits(shifter);
         3'b010:  aluResult = {31'd0, lt};
         3'b011:  aluResult = {31'd0, ltu};
         3'b100:  aluResult = rs1Value ^ aluIn2;
         3'b101:  aluResult = shifter;
         3'b110:  aluResult = rs1Value | aluIn2;
         default: aluResult = rs1Value & aluIn2;
      endcase
   end

   // BEQ BNE BLT BGE BLTU BGEU, 010 and 011 never taken
   always_comb begin
      case (dec.funct3)
         3'b000:  branchTaken = eq;
         3'b001:  branchTaken = !eq;
         3'b100:  branchTaken = lt;
         3'b101:  branchTaken = !lt;
         3'b110:  branchTaken = ltu;
         3'b111:  branchTaken = !ltu;
         default: branchTaken = 1'b0;
      endcase
   end

endmodule

// File: verilog/loadStoreAlign.sv
// Load/store alignment unit
// Effective address adder
// Byte and halfword load extraction with sign extension
// Store lane replication and write mask
module loadStoreAlign import rvCorePkg::*; #(
   parameter int addrWidth = 24
) (
   input  dataWord                rs1Value,
   input  dataWord                rs2Value,
   input  decodedInstr            dec,
   input  dataWord                memRdata,
   input  logic                   storeEnable,
   output logic [addrWidth-1:0]   lsAddr,
   output storeReq                store,
   output dataWord                loadData
);

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;
   byteMask     laneMask;

   // Stores use S offset, loads use I offset
   assign lsAddr = rs1Value[addrWidth-1:0] +
                   (dec.isStore ? dec.sImm[addrWidth-1:0] : dec.iImm[addrWidth-1:0]);

   // funct3 low bits, 00 byte, 01 halfword, 10 word
   assign byteAccess = (dec.funct3[1:0] == 2'b00);
   assign halfAccess = (dec.funct3[1:0] == 2'b01);

   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   // funct3 bit 2 set means LBU or LHU
   assign loadSign = !dec.funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

   // Low bytes copied into every lane the mask may pick
   assign store.data[7:0]   = rs2Value[7:0];
   assign store.data[15:8]  = lsAddr[0] ? rs2Value[7:0] : rs2Value[15:8];
   assign store.data[23:16] = lsAddr[1] ? rs2Value[7:0] : rs2Value[23:16];
   assign store.data[31:24] = lsAddr[0] ? rs2Value[7:0] :
                              lsAddr[1] ? rs2Value[15:8] : rs2Value[31:24];

   assign laneMask = byteAccess ? (4'b0001 << lsAddr[1:0]) :
                     halfAccess ? (lsAddr[1] ? 4'b1100 : 4'b0011) :
                                  4'b1111;

   assign store.mask = {4{storeEnable}} & laneMask;

   // The addressed lane of an enabled store carries the low byte of rs2
   storeLaneData: assert final (!storeEnable ||
                                (store.data[8*lsAddr[1:0] +: 8] == rs2Value[7:0]))
      else $error("store lane %0d holds %h instead of %h", lsAddr[1:0],
                  store.data[8*lsAddr[1:0] +: 8], rs2Value[7:0]);

endmodule

// File: verilog/fetchExecuteFsm.sv
// Fetch/execute state machine
// Program counter, instruction latch and next-PC selection
// Memory strobes, address select and write-back mux
module fetchExecuteFsm import rvCorePkg::*; #(
   parameter dataWord resetAddr = 32'h0000_0000,
   parameter int      addrWidth = 24
) (
   input  logic                 clk,
   input  logic                 reset,
   input  dataWord              memRdata,
   input  logic                 memRbusy,
   input  logic                 memWbusy,
   input  decodedInstr          dec,
   input  dataWord              aluResult,
   input  dataWord              aluSum,
   input  logic                 branchTaken,
   input  dataWord              loadData,
   input  logic [addrWidth-1:0] lsAddr,
   output dataWord              instrWord,
   output logic                 fetchCapture,
   output logic [addrWidth-1:0] pcAddr,
   output logic                 memRstrb,
   output logic                 storeEnable,
   output logic                 wbEnable,
   output dataWord              wbData
);

   coreState             state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm;
   logic [addrWidth-1:0] nextPc;
   logic                 loadPending;

   assign pcPlus4 = pc + addrWidth'(4);
   // JAL and AUIPC pick their immediates, branches use B
   assign pcPlusImm = pc + (dec.isJal   ? dec.jImm[addrWidth-1:0] :
                            dec.isAuipc ? dec.uImm[addrWidth-1:0] :
                                          dec.bImm[addrWidth-1:0]);
   assign nextPc = dec.isJalr ? {aluSum[addrWidth-1:1], 1'b0} :
                   (dec.isJal || (dec.isBranch && branchTaken)) ? pcPlusImm :
                   pcPlus4;

   // Instruction fetch address until execute, then data address
   assign pcAddr = (state == fetchInstr || state == waitInstr) ? pc : lsAddr;

   assign fetchCapture = (state == waitInstr) && !memRbusy;
   assign memRstrb     = (state == fetchInstr) || (state == execute && dec.isLoad);
   assign storeEnable  = (state == execute) && dec.isStore;
   // Load data rewritten each waitMem cycle, last one wins
   assign wbEnable = ((state == execute) && !(dec.isBranch || dec.isStore)) ||
                     ((state == waitMem) && loadPending);

   always_comb begin
      if (dec.isLui) wbData = dec.uImm;
      else if (dec.isAluImm || dec.isAluReg) wbData = aluResult;
      else if (dec.isAuipc) wbData = dataWord'(pcPlusImm);
      else if (dec.isJal || dec.isJalr) wbData = dataWord'(pcPlus4);
      else if (dec.isLoad) wbData = loadData;
      // SYSTEM and unknown opcodes write zero
      else wbData = '0;
   end

   always_ff @(posedge clk) begin
      if (fetchCapture) begin
         instrWord <= memRdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by draining any pending write
         state       <= waitMem;
         pc          <= resetAddr[addrWidth-1:0];
         loadPending <= 1'b0;
      end else begin
         case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!memRbusy) state <= execute;
            end
            execute: begin
               pc          <= nextPc;
               loadPending <= dec.isLoad;
               state       <= (dec.isLoad || dec.isStore) ? waitMem : fetchInstr;
            end
            default: begin
               if (!memRbusy && !memWbusy) state <= fetchInstr;
            end
         endcase
      end
   end

   // A read strobe goes out only while the memory is idle
   rstrbWhenIdle: assert property (@(posedge clk) disable iff (!reset)
      memRstrb |-> (!memRbusy && !memWbusy));

   stateKnown: assert property (@(posedge clk) disable iff (!reset)
      !$isunknown(state) && (state inside {fetchInstr, waitInstr, execute, waitMem}));

endmodule

// File: verilog/rv32Core.sv
// RV32I multi-cycle core top level
// Wires FSM, decoder, register file, ALU and load/store unit
// Drives the shared memory port
module rv32Core import rvCorePkg::*; #(
   parameter dataWord resetAddr = 32'h0000_0000,
   parameter int      addrWidth = 24
) (
   input  logic    clk,
   input  logic    reset,
   output dataWord memAddr,
   output dataWord memWdata,
   output byteMask memWmask,
   input  dataWord memRdata,
   output logic    memRstrb,
   input  logic    memRbusy,
   input  logic    memWbusy
);

   dataWord              instrWord;
   decodedInstr          dec;
   logic                 fetchCapture;
   logic                 wbEnable;
   dataWord              wbData;
   dataWord              rs1Value;
   dataWord              rs2Value;
   dataWord              aluResult;
   dataWord              aluSum;
   logic                 branchTaken;
   logic [addrWidth-1:0] lsAddr;
   logic [addrWidth-1:0] pcAddr;
   logic                 storeEnable;
   storeReq              store;
   dataWord              loadData;

   fetchExecuteFsm #(
      .resetAddr(resetAddr),
      .addrWidth(addrWidth)
   ) fetchExecuteFsm_inst (
      .clk(clk),
      .reset(reset),
      .memRdata(memRdata),
      .memRbusy(memRbusy),
      .memWbusy(memWbusy),
      .dec(dec),
      .aluResult(aluResult),
      .aluSum(aluSum),
      .branchTaken(branchTaken),
      .loadData(loadData),
      .lsAddr(lsAddr),
      .instrWord(instrWord),
      .fetchCapture(fetchCapture),
      .pcAddr(pcAddr),
      .memRstrb(memRstrb),
      .storeEnable(storeEnable),
      .wbEnable(wbEnable),
      .wbData(wbData)
   );

   instrDecoder instrDecoder_inst (
      .instrWord(instrWord),
      .dec(dec)
   );

   // Source fields come from the bus in the capture cycle
   registerFile registerFile_inst (
      .clk(clk),
      .fetchWord(memRdata),
      .fetchCapture(fetchCapture),
      .wbEnable(wbEnable),
      .rd(dec.rd),
      .wbData(wbData),
      .rs1Value(rs1Value),
      .rs2Value(rs2Value)
   );

   aluUnit aluUnit_inst (
      .dec(dec),
      .rs1Value(rs1Value),
      .rs2Value(rs2Value),
      .aluResult(aluResult),
      .aluSum(aluSum),
      .branchTaken(branchTaken)
   );

   loadStoreAlign #(
      .addrWidth(addrWidth)
   ) loadStoreAlign_inst (
      .rs1Value(rs1Value),
      .rs2Value(rs2Value),
      .dec(dec),
      .memRdata(memRdata),
      .storeEnable(storeEnable),
      .lsAddr(lsAddr),
      .store(store),
      .loadData(loadData)
   );

   // Narrow internal address zero-extended onto the bus
   assign memAddr  = dataWord'(pcAddr);
   assign memWdata = store.data;
   assign memWmask = store.mask;

endmodule

// File: dv/tbMemory.sv
// Word-addressed memory model for the core testbench
// Registered reads, byte-masked writes and a write log
// Optional random busy stretching on reads and writes
module tbMemory import rvCorePkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    stretch,
   input  dataWord memAddr,
   input  dataWord memWdata,
   input  byteMask memWmask,
   input  logic    memRstrb,
   output dataWord memRdata,
   output logic    memRbusy,
   output logic    memWbusy
);

   dataWord    mem [1024];
   dataWord    logAddr [32];
   dataWord    logData [32];
   byteMask    logMask [32];
   int         writeCount;
   int         readWait;
   int         writeWait;
   logic [9:0] wordIdx;

   // 4 KB window, byte address bits 11:2
   assign wordIdx = memAddr[11:2];

   initial begin
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
   end

   always @(posedge clk) begin
      if (!reset) begin
         readWait = 0;
         writeWait = 0;
         writeCount <= 0;
      end else begin
         if (readWait > 0) readWait--;
         if (writeWait > 0) writeWait--;
         // Read data held until the next strobe
         if (memRstrb) begin
            memRdata <= #1 mem[wordIdx];
            if (stretch) readWait = $urandom_range(3);
         end
         if (memWmask != 4'b0000) begin
            for (int b = 0; b < 4; b++) begin
               if (memWmask[b]) mem[wordIdx][8*b +: 8] <= memWdata[8*b +: 8];
            end
            if (writeCount < 32) begin
               logAddr[writeCount] <= memAddr;
               logData[writeCount] <= memWdata;
               logMask[writeCount] <= memWmask;
            end
            writeCount <= writeCount + 1;
            if (stretch) writeWait = $urandom_range(3);
         end
      end
      memRbusy <= #1 (readWait != 0);
      memWbusy <= #1 (writeWait != 0);
   end

endmodule

// File: dv/coreTb.sv
// Testbench for the RV32I multi-cycle core
// Hand-assembled programs with expected write sequences
// Reset check, write log compare and memory image compare
module coreTb import rvCorePkg::*; ();

   localparam dataWord resetAddr = 32'h0000_0100;
   localparam dataWord loadWord = 32'h80F1_7F22;
   localparam int maxCases = 16;
   localparam int maxWords = 16;
   localparam int maxWrites = 8;
   localparam int timeoutCycles = 2000;
   localparam logic [6:0] immOp = 7'b0010011;
   localparam logic [6:0] loadOp = 7'b0000011;
   localparam logic [6:0] luiOp = 7'b0110111;
   localparam logic [6:0] auipcOp = 7'b0010111;
   localparam logic [6:0] jalrOp = 7'b1100111;

   logic    clk;
   logic    reset;
   logic    stretch;
   dataWord memAddr;
   dataWord memWdata;
   byteMask memWmask;
   dataWord memRdata;
   logic    memRstrb;
   logic    memRbusy;
   logic    memWbusy;

   // Stimulus and expectation table
   dataWord progWords [maxCases][maxWords];
   int      progLen [maxCases];
   dataWord expAddr [maxCases][maxWrites];
   byteMask expMask [maxCases][maxWrites];
   dataWord expData [maxCases][maxWrites];
   int      expCount [maxCases];
   logic    caseStretch [maxCases];
   int      nCases;
   int      mismatchErrors;
   int      otherErrors;

   rv32Core #(
      .resetAddr(resetAddr),
      .addrWidth(24)
   ) rv32Core_inst (
      .clk(clk),
      .reset(reset),
      .memAddr(memAddr),
      .memWdata(memWdata),
      .memWmask(memWmask),
      .memRdata(memRdata),
      .memRstrb(memRstrb),
      .memRbusy(memRbusy),
      .memWbusy(memWbusy)
   );

   tbMemory tbMemory_inst (
      .clk(clk),
      .reset(reset),
      .stretch(stretch),
      .memAddr(memAddr),
      .memWdata(memWdata),
      .memWmask(memWmask),
      .memRstrb(memRstrb),
      .memRdata(memRdata),
      .memRbusy(memRbusy),
      .memWbusy(memWbusy)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Instruction encoders
   function automatic dataWord rType(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
   endfunction

   function automatic dataWord iType(input logic [6:0] op, input logic [2:0] f3,
                                     input int rd, input int rs1, input int imm);
      return {12'(imm), 5'(rs1), f3, 5'(rd), op};
   endfunction

   function automatic dataWord sType(input logic [2:0] f3, input int rs2,
                                     input int rs1, input int imm);
      logic [11:0] i;
      i = 12'(imm);
      return {i[11:5], 5'(rs2), 5'(rs1), f3, i[4:0], 7'b0100011};
   endfunction

   function automatic dataWord bType(input logic [2:0] f3, input int rs1,
                                     input int rs2, input int imm);
      logic [12:0] i;
      i = 13'(imm);
      return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011};
   endfunction

   function automatic dataWord uType(input logic [6:0] op, input int rd, input int imm20);
      return {20'(imm20), 5'(rd), op};
   endfunction

   function automatic dataWord jType(input int rd, input int imm);
      logic [20:0] i;
      i = 21'(imm);
      return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
   endfunction

   function automatic dataWord storeWord(input int rs2, input int addr);
      return sType(3'b010, rs2, 0, addr);
   endfunction

   // Load result per RV32I extension rules
   function automatic dataWord expectedLoad(input logic [2:0] f3, input int off);
      logic [7:0]  b;
      logic [15:0] h;
      b = loadWord[8*off +: 8];
      h = loadWord[16*(off/2) +: 16];
      case (f3)
         3'b000:  return {{24{b[7]}}, b};
         3'b100:  return {24'd0, b};
         3'b001:  return {{16{h[15]}}, h};
         3'b101:  return {16'd0, h};
         default: return loadWord;
      endcase
   endfunction

   function automatic dataWord laneBits(input byteMask m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   // Initial memory contents, every bit of the index matters
   function automatic dataWord fillWord(input int i);
      return dataWord'((i + 1) * 32'h9E37_79B9);
   endfunction

   task automatic put(input dataWord w);
      progWords[nCases][progLen[nCases]] = w;
      progLen[nCases]++;
   endtask

   task automatic want(input dataWord a, input byteMask m, input dataWord d);
      expAddr[nCases][expCount[nCases]] = a;
      expMask[nCases][expCount[nCases]] = m;
      expData[nCases][expCount[nCases]] = d;
      expCount[nCases]++;
   endtask

   // Load to x1 then store it to the next result slot
   task automatic addLoad(input logic [2:0] f3, input int off);
      int slot;
      slot = expCount[nCases];
      put(iType(loadOp, f3, 1, 0, 32'h400 + off));
      put(storeWord(1, 32'h600 + 4 * slot));
      want(32'h600 + 4 * slot, 4'hF, expectedLoad(f3, off));
   endtask

   task automatic mismatch(input string name, input dataWord exp, input dataWord act);
      mismatchErrors++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
   endtask

   task automatic buildTable();
      dataWord a;
      dataWord b;
      nCases = 0;
      for (int c = 0; c < maxCases; c++) begin
         progLen[c] = 0;
         expCount[c] = 0;
         caseStretch[c] = 1'b0;
      end
      // Register ALU ops on -20 and 3
      a = 32'hFFFF_FFEC;
      b = 32'd3;
      put(iType(immOp, 3'b000, 1, 0, -20));
      put(iType(immOp, 3'b000, 2, 0, 3));
      put(rType(7'b0100000, 3'b000, 3, 1, 2));
      put(storeWord(3, 32'h600));
      want(32'h600, 4'hF, a - b);
      put(rType(7'b0100000, 3'b101, 4, 1, 2));
      put(storeWord(4, 32'h604));
      want(32'h604, 4'hF, dataWord'($signed(a) >>> b[4:0]));
      put(rType(7'b0000000, 3'b101, 5, 1, 2));
      put(storeWord(5, 32'h608));
      want(32'h608, 4'hF, a >> b[4:0]);
      put(rType(7'b0000000, 3'b010, 6, 1, 2));
      put(storeWord(6, 32'h60C));
      want(32'h60C, 4'hF, {31'd0, $signed(a) < $signed(b)});
      put(rType(7'b0000000, 3'b011, 7, 1, 2));
      put(storeWord(7, 32'h610));
      want(32'h610, 4'hF, {31'd0, a < b});
      put(rType(7'b0000000, 3'b001, 8, 1, 2));
      put(storeWord(8, 32'h614));
      want(32'h614, 4'hF, a << b[4:0]);
      put(jType(0, 0));
      nCases++;
      // Immediate forms, LUI and AUIPC
      a = 32'h1234_5000;
      put(uType(luiOp, 1, 32'h12345));
      put(storeWord(1, 32'h600));
      want(32'h600, 4'hF, a);
      put(iType(immOp, 3'b100, 2, 1, -1));
      put(storeWord(2, 32'h604));
      want(32'h604, 4'hF, ~a);
      put(iType(immOp, 3'b111, 3, 2, 32'h7F0));
      put(storeWord(3, 32'h608));
      want(32'h608, 4'hF, ~a & 32'h7F0);
      put(iType(immOp, 3'b101, 4, 2, 32'h408));
      put(storeWord(4, 32'h60C));
      want(32'h60C, 4'hF, dataWord'($signed(~a) >>> 8));
      put(iType(immOp, 3'b010, 5, 2, -1));
      put(storeWord(5, 32'h610));
      want(32'h610, 4'hF, {31'd0, $signed(~a) < -1});
      want(32'h614, 4'hF, resetAddr + 4 * progLen[nCases] + 32'h1000);
      put(uType(auipcOp, 6, 1));
      put(storeWord(6, 32'h614));
      put(iType(immOp, 3'b001, 7, 1, 4));
      put(storeWord(7, 32'h618));
      want(32'h618, 4'hF, a << 4);
      put(jType(0, 0));
      nCases++;
      // LB at every offset, LBU at 0 to 2
      for (int k = 0; k < 4; k++) addLoad(3'b000, k);
      for (int k = 0; k < 3; k++) addLoad(3'b100, k);
      put(jType(0, 0));
      nCases++;
      // LBU 3, halfwords and word
      addLoad(3'b100, 3);
      addLoad(3'b001, 0);
      addLoad(3'b001, 2);
      addLoad(3'b101, 0);
      addLoad(3'b101, 2);
      addLoad(3'b010, 0);
      put(jType(0, 0));
      nCases++;
      // SB and SH lanes, compared only on masked bytes
      a = 32'hA1B2_C3D4;
      put(uType(luiOp, 1, 32'hA1B2C));
      put(iType(immOp, 3'b000, 1, 1, 32'h3D4));
      put(sType(3'b000, 1, 0, 32'h600));
      want(32'h600, 4'b0001, {4{a[7:0]}});
      put(sType(3'b000, 1, 0, 32'h601));
      want(32'h601, 4'b0010, {4{a[7:0]}});
      put(sType(3'b000, 1, 0, 32'h606));
      want(32'h606, 4'b0100, {4{a[7:0]}});
      put(sType(3'b000, 1, 0, 32'h60B));
      want(32'h60B, 4'b1000, {4{a[7:0]}});
      put(sType(3'b001, 1, 0, 32'h60C));
      want(32'h60C, 4'b0011, {2{a[15:0]}});
      put(sType(3'b001, 1, 0, 32'h612));
      want(32'h612, 4'b1100, {2{a[15:0]}});
      put(jType(0, 0));
      nCases++;
      // Taken branches skip a stray store to 0x700
      put(iType(immOp, 3'b000, 1, 0, 5));
      put(iType(immOp, 3'b000, 2, 0, -3));
      put(bType(3'b000, 1, 1, 8));
      put(storeWord(1, 32'h700));
      put(bType(3'b001, 1, 2, 8));
      put(storeWord(1, 32'h700));
      put(bType(3'b100, 2, 1, 8));
      put(storeWord(1, 32'h700));
      put(bType(3'b101, 1, 2, 8));
      put(storeWord(1, 32'h700));
      put(bType(3'b110, 1, 2, 8));
      put(storeWord(1, 32'h700));
      put(bType(3'b111, 2, 1, 8));
      put(storeWord(1, 32'h700));
      put(storeWord(1, 32'h600));
      want(32'h600, 4'hF, 32'd5);
      put(jType(0, 0));
      nCases++;
      // Not-taken branches fall into their stores
      put(iType(immOp, 3'b000, 1, 0, 5));
      put(iType(immOp, 3'b000, 2, 0, -3));
      put(bType(3'b000, 1, 2, 8));
      put(storeWord(1, 32'h600));
      put(bType(3'b001, 1, 1, 8));
      put(storeWord(1, 32'h604));
      put(bType(3'b100, 1, 2, 8));
      put(storeWord(1, 32'h608));
      put(bType(3'b101, 2, 1, 8));
      put(storeWord(1, 32'h60C));
      put(bType(3'b110, 2, 1, 8));
      put(storeWord(1, 32'h610));
      put(bType(3'b111, 1, 2, 8));
      put(storeWord(1, 32'h614));
      for (int k = 0; k < 6; k++) want(32'h600 + 4 * k, 4'hF, 32'd5);
      put(jType(0, 0));
      nCases++;
      // JAL, JALR with odd target sum, write to x0
      put(iType(immOp, 3'b000, 1, 0, 7));
      put(jType(5, 8));
      put(storeWord(1, 32'h700));
      put(storeWord(5, 32'h600));
      want(32'h600, 4'hF, resetAddr + 8);
      put(iType(immOp, 3'b000, 6, 0, resetAddr + 32'h25));
      put(iType(jalrOp, 3'b000, 7, 6, 4));
      for (int k = 0; k < 4; k++) put(storeWord(1, 32'h700));
      put(storeWord(7, 32'h604));
      want(32'h604, 4'hF, resetAddr + 24);
      put(iType(immOp, 3'b000, 0, 1, 5));
      put(storeWord(0, 32'h608));
      want(32'h608, 4'hF, 32'd0);
      put(jType(0, 0));
      nCases++;
      // Same cases again under busy stretching
      for (int c = 0; c < 8; c++) begin
         progLen[c + 8] = progLen[c];
         expCount[c + 8] = expCount[c];
         caseStretch[c + 8] = 1'b1;
         for (int k = 0; k < maxWords; k++) progWords[c + 8][k] = progWords[c][k];
         for (int k = 0; k < maxWrites; k++) begin
            expAddr[c + 8][k] = expAddr[c][k];
            expMask[c + 8][k] = expMask[c][k];
            expData[c + 8][k] = expData[c][k];
         end
      end
      nCases = 16;
   endtask

   task automatic runCase(input int c);
      dataWord shadow [1024];
      dataWord lanes;
      int      cycles;
      int      idx;
      @(posedge clk);
      #1;
      reset = 1'b0;
      stretch = caseStretch[c];
      for (int i = 0; i < 1024; i++) tbMemory_inst.mem[i] = fillWord(i);
      for (int k = 0; k < progLen[c]; k++) tbMemory_inst.mem[resetAddr[11:2] + k] = progWords[c][k];
      tbMemory_inst.mem[256] = loadWord;
      for (int i = 0; i < 1024; i++) shadow[i] = tbMemory_inst.mem[i];
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b1;
      // First fetch must come from the reset address
      cycles = 0;
      @(negedge clk);
      while (!memRstrb && cycles < timeoutCycles) begin
         @(negedge clk);
         cycles++;
      end
      assert (cycles < timeoutCycles) else begin
         otherErrors++;
         $display("Case %0d: no read strobe after reset", c);
      end
      assert (memAddr == resetAddr) else mismatch("memAddr", resetAddr, memAddr);
      while (tbMemory_inst.writeCount < expCount[c] && cycles < timeoutCycles) begin
         @(negedge clk);
         cycles++;
      end
      assert (cycles < timeoutCycles) else begin
         otherErrors++;
         $display("Case %0d: timed out with %0d of %0d writes", c,
                  tbMemory_inst.writeCount, expCount[c]);
      end
      // Short window to catch stray writes
      for (int i = 0; i < 40; i++) @(negedge clk);
      assert (tbMemory_inst.writeCount == expCount[c]) else begin
         otherErrors++;
         $display("Case %0d: saw %0d writes instead of %0d", c,
                  tbMemory_inst.writeCount, expCount[c]);
      end
      for (int k = 0; k < expCount[c] && k < tbMemory_inst.writeCount; k++) begin
         lanes = laneBits(expMask[c][k]);
         assert (tbMemory_inst.logAddr[k] == expAddr[c][k])
            else mismatch("memAddr", expAddr[c][k], tbMemory_inst.logAddr[k]);
         assert (tbMemory_inst.logMask[k] == expMask[c][k])
            else mismatch("memWmask", 32'(expMask[c][k]), 32'(tbMemory_inst.logMask[k]));
         assert ((tbMemory_inst.logData[k] & lanes) == (expData[c][k] & lanes))
            else mismatch("memWdata", expData[c][k] & lanes, tbMemory_inst.logData[k] & lanes);
         idx = expAddr[c][k][11:2];
         shadow[idx] = (shadow[idx] & ~lanes) | (expData[c][k] & lanes);
      end
      // Neighboring bytes keep their old contents
      for (int k = 0; k < expCount[c]; k++) begin
         idx = expAddr[c][k][11:2];
         assert (tbMemory_inst.mem[idx] == shadow[idx])
            else mismatch($sformatf("mem[%0d]", idx), shadow[idx], tbMemory_inst.mem[idx]);
      end
   endtask

   initial begin
      void'($urandom(78441));
      reset = 1'b0;
      stretch = 1'b0;
      mismatchErrors = 0;
      otherErrors = 0;
      buildTable();
      for (int c = 0; c < nCases; c++) runCase(c);
      $display("Error counts: %0d mismatches, %0d other failures",
               mismatchErrors, otherErrors);
      if (mismatchErrors == 0 && otherErrors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: sim.f
verilog/rvCorePkg.sv
verilog/instrDecoder.sv
verilog/registerFile.sv
verilog/aluUnit.sv
verilog/loadStoreAlign.sv
verilog/fetchExecuteFsm.sv
verilog/rv32Core.sv
dv/tbMemory.sv
dv/coreTb.sv

// File: Bender.yml
package:
  name: rv32_core

sources:
  - verilog/rvCorePkg.sv
  - verilog/instrDecoder.sv
  - verilog/registerFile.sv
  - verilog/aluUnit.sv
  - verilog/loadStoreAlign.sv
  - verilog/fetchExecuteFsm.sv
  - verilog/rv32Core.sv
  - target: simulation
    files:
      - dv/tbMemory.sv
      - dv/coreTb.sv
